/* flist.f */
src/fifo_bridge_pkg.sv
src/gray_ptr_sync.sv
src/dual_clock_ram.sv
src/async_fifo.sv
src/apb_fifo_port.sv
src/stream_read_stage.sv
src/fifo_bridge_top.sv
sim/tb_clocks.sv
sim/fifo_bridge_checker.sv
sim/tb_fifo_bridge.sv

/* Bender.yml */
package:
  name: fifo_bridge

sources:
  - src/fifo_bridge_pkg.sv
  - src/gray_ptr_sync.sv
  - src/dual_clock_ram.sv
  - src/async_fifo.sv
  - src/apb_fifo_port.sv
  - src/stream_read_stage.sv
  - src/fifo_bridge_top.sv
  - target: simulation
    files:
      - sim/tb_clocks.sv
      - sim/fifo_bridge_checker.sv
      - sim/tb_fifo_bridge.sv

/* sim/tb_fifo_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fifo_bridge;

	import fifo_bridge_pkg::*;

	localparam int DW = DEFAULT_DATA_W;

	typedef enum logic [2:0] {
		OP_WR,
		OP_WR_STALL,
		OP_RD,
		OP_HOLD,
		OP_FREE,
		OP_WAIT_VALID,
		OP_DRAIN
	} op_t;

	// For reads the data column holds the expected prdata.
	typedef struct packed {
		op_t                   op;
		logic [APB_ADDR_W-1:0] addr;
		logic [DW-1:0]         data;
		logic                  err;
	} row_t;

	logic                  wclk;
	logic                  rclk;
	logic                  reset_n;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	logic [DW-1:0]         pwdata;
	logic [DW-1:0]         prdata;
	logic                  pready;
	logic                  pslverr;
	logic                  out_valid;
	logic [DW-1:0]         out_data;
	logic                  out_ready;
	logic                  exp_pslverr;
	logic [DW-1:0]         exp_rdata;
	logic                  exp_check_rdata;
	logic                  exp_stall;
	logic                  check_end;
	logic                  hold_ready;
	logic                  xfer_done;
	logic                  table_ready;
	logic [31:0]           lfsr;
	int                    exp_words;
	int                    apb_errors;
	int                    stream_errors;
	row_t                  rows [$];

	tb_clocks u_clocks (
		.rclk    (rclk),
		.wclk    (wclk),
		.reset_n (reset_n)
	);

	fifo_bridge_top UUT (
		.wclk      (wclk),
		.rclk      (rclk),
		.reset_n   (reset_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ready (out_ready)
	);

	fifo_bridge_checker #(
		.DATA_W (DW)
	) u_checker (
		.reset_n         (reset_n),
		.wclk            (wclk),
		.rclk            (rclk),
		.psel            (psel),
		.penable         (penable),
		.pwrite          (pwrite),
		.paddr           (paddr),
		.pwdata          (pwdata),
		.prdata          (prdata),
		.pready          (pready),
		.pslverr         (pslverr),
		.out_valid       (out_valid),
		.out_data        (out_data),
		.out_ready       (out_ready),
		.exp_pslverr     (exp_pslverr),
		.exp_rdata       (exp_rdata),
		.exp_check_rdata (exp_check_rdata),
		.exp_stall       (exp_stall),
		.exp_words       (exp_words),
		.check_end       (check_end),
		.apb_errors      (apb_errors),
		.stream_errors   (stream_errors)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// STATUS holds the fill level in the low bits and the full flag in bit 7.
	function automatic logic [DW-1:0] status_value(input int level, input logic full_flag);
		logic [DW-1:0] v;
		v = DW'(level);
		v[7] = full_flag;
		return v;
	endfunction

	function automatic void add_row(input op_t op, input logic [APB_ADDR_W-1:0] addr,
		input logic [DW-1:0] data, input logic err);
		row_t r;
		r.op = op;
		r.addr = addr;
		r.data = data;
		r.err = err;
		rows.push_back(r);
	endfunction

	task automatic build_table();
		add_row(OP_RD, ADDR_STATUS, status_value(0, 1'b0), 1'b0);
		add_row(OP_FREE, '0, '0, 1'b0);
		for (int i = 0; i < 8; i++) begin
			add_row(OP_WR, ADDR_DATA, DW'(i * 29 + 3), 1'b0);
		end
		add_row(OP_WR, 4'h8, 8'h5a, 1'b1);
		add_row(OP_WR, ADDR_STATUS, 8'h66, 1'b1);
		add_row(OP_RD, ADDR_DATA, '0, 1'b1);
		add_row(OP_DRAIN, '0, '0, 1'b0);
		// Park one word in the output register, then fill every FIFO slot behind it.
		add_row(OP_HOLD, '0, '0, 1'b0);
		add_row(OP_WR, ADDR_DATA, 8'hc1, 1'b0);
		add_row(OP_WAIT_VALID, '0, '0, 1'b0);
		add_row(OP_RD, ADDR_STATUS, status_value(0, 1'b0), 1'b0);
		for (int n = 1; n <= 16; n++) begin
			add_row(OP_WR, ADDR_DATA, DW'(8'h80 ^ (n * 7)), 1'b0);
			if (n == 4 || n == 16) begin
				add_row(OP_RD, ADDR_STATUS, status_value(n, n == 16), 1'b0);
			end
		end
		add_row(OP_WR_STALL, ADDR_DATA, 8'hee, 1'b0);
		add_row(OP_DRAIN, '0, '0, 1'b0);
		add_row(OP_RD, ADDR_STATUS, status_value(0, 1'b0), 1'b0);
		for (int i = 0; i < 4; i++) begin
			add_row(OP_WR, ADDR_DATA, DW'(8'hf0 + i), 1'b0);
		end
		add_row(OP_DRAIN, '0, '0, 1'b0);
	endtask

	task automatic apb_transfer(input logic write, input row_t r, input logic stall);
		int waits;
		waits = 0;
		@(negedge wclk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = r.addr;
		pwdata = write ? r.data : '0;
		exp_pslverr = r.err;
		exp_rdata = r.data;
		exp_check_rdata = !write && !r.err;
		exp_stall = stall;
		@(negedge wclk);
		penable = 1'b1;
		@(negedge wclk);
		while (!xfer_done) begin
			// A few wait states in, open the stream so a FIFO slot frees up.
			if (stall && waits == 4) begin
				hold_ready = 1'b0;
			end
			waits++;
			@(negedge wclk);
		end
		psel = 1'b0;
		penable = 1'b0;
	endtask

	always @(posedge wclk or negedge reset_n) begin
		if (!reset_n) begin
			xfer_done <= 1'b0;
		end else begin
			xfer_done <= psel && penable && pready;
		end
	end

	initial begin
		lfsr = 32'h4b3d;
		out_ready = 1'b0;
		forever begin
			@(negedge rclk);
			if (hold_ready) begin
				out_ready = 1'b0;
			end else begin
				lfsr = lfsr_next(lfsr);
				out_ready = lfsr[0];
			end
		end
	end

	initial begin
		int limit;
		int cycle_count;
		cycle_count = 0;
		wait (table_ready === 1'b1);
		limit = rows.size() * 40 + 200;
		while (cycle_count < limit) begin
			@(posedge rclk);
			cycle_count++;
		end
		$display("Timeout expired after %0d rclk cycles before the table was done", limit);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int idle;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		exp_pslverr = 1'b0;
		exp_rdata = '0;
		exp_check_rdata = 1'b0;
		exp_stall = 1'b0;
		check_end = 1'b0;
		hold_ready = 1'b0;
		exp_words = 0;
		build_table();
		foreach (rows[i]) begin
			if (rows[i].op inside {OP_WR, OP_WR_STALL} && rows[i].addr == ADDR_DATA) begin
				exp_words++;
			end
		end
		table_ready = 1'b1;
		@(posedge reset_n);
		foreach (rows[i]) begin
			case (rows[i].op)
				OP_WR:       apb_transfer(1'b1, rows[i], 1'b0);
				OP_WR_STALL: apb_transfer(1'b1, rows[i], 1'b1);
				OP_RD:       apb_transfer(1'b0, rows[i], 1'b0);
				OP_HOLD:     hold_ready = 1'b1;
				OP_FREE:     hold_ready = 1'b0;
				default: begin
					if (rows[i].op == OP_DRAIN) begin
						// The stream is drained once out_valid stays low longer than
						// the push-to-valid latency.
						idle = 0;
						while (idle < SYNC_STAGES + 4) begin
							@(negedge rclk);
							idle = (out_valid === 1'b1) ? 0 : idle + 1;
						end
					end else begin
						while (out_valid !== 1'b1) begin
							@(negedge rclk);
						end
					end
					// Let the read pointer reach the write side before the next STATUS read.
					repeat (SYNC_STAGES + 2) @(negedge wclk);
				end
			endcase
		end
		@(negedge rclk);
		check_end = 1'b1;
		@(negedge rclk);
		$display("Closing report: %0d APB errors, %0d stream errors", apb_errors, stream_errors);
		if (apb_errors + stream_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/fifo_bridge_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_bridge_checker #(
	parameter int DATA_W = fifo_bridge_pkg::DEFAULT_DATA_W
) (
	input  logic                                  reset_n,
	input  logic                                  wclk,
	input  logic                                  rclk,
	input  logic                                  psel,
	input  logic                                  penable,
	input  logic                                  pwrite,
	input  logic [fifo_bridge_pkg::APB_ADDR_W-1:0] paddr,
	input  logic [DATA_W-1:0]                     pwdata,
	input  logic [DATA_W-1:0]                     prdata,
	input  logic                                  pready,
	input  logic                                  pslverr,
	input  logic                                  out_valid,
	input  logic [DATA_W-1:0]                     out_data,
	input  logic                                  out_ready,
	input  logic                                  exp_pslverr,
	input  logic [DATA_W-1:0]                     exp_rdata,
	input  logic                                  exp_check_rdata,
	input  logic                                  exp_stall,
	input  int                                    exp_words,
	input  logic                                  check_end,
	output int                                    apb_errors,
	output int                                    stream_errors
);

	import fifo_bridge_pkg::*;

	logic [DATA_W-1:0] expected_q [$];
	logic [DATA_W-1:0] head;
	int                wait_cycles;
	int                words_in;
	int                words_out;

	initial begin
		apb_errors = 0;
		stream_errors = 0;
		wait_cycles = 0;
		words_in = 0;
		words_out = 0;
	end

	// Nothing may be offered or acknowledged straight out of reset.
	initial begin
		@(posedge reset_n);
		@(negedge rclk);
		if (out_valid !== 1'b0 || pready !== 1'b0) begin
			apb_errors++;
			$display("ERROR %0t: out_valid=%b pready=%b after reset, expected both low",
				$time, out_valid, pready);
		end
	end

	always @(posedge wclk) begin
		if (reset_n && psel && penable) begin
			if (pready) begin
				if (pslverr !== exp_pslverr) begin
					apb_errors++;
					$display("ERROR %0t: paddr %h pslverr %b, expected %b",
						$time, paddr, pslverr, exp_pslverr);
				end
				if (exp_check_rdata && prdata !== exp_rdata) begin
					apb_errors++;
					$display("ERROR %0t: STATUS read %h, expected %h", $time, prdata, exp_rdata);
				end
				if ((wait_cycles > 0) != exp_stall) begin
					apb_errors++;
					$display("ERROR %0t: transfer took %0d wait states, stall expected %b",
						$time, wait_cycles, exp_stall);
				end
				// Every completed DATA write is a word the stream owes us.
				if (pwrite && paddr == ADDR_DATA) begin
					expected_q.push_back(pwdata);
					words_in++;
				end
				wait_cycles = 0;
			end else begin
				wait_cycles++;
			end
		end
	end

	always @(posedge rclk) begin
		if (reset_n && out_valid && out_ready) begin
			words_out++;
			if (expected_q.size() == 0) begin
				stream_errors++;
				$display("ERROR %0t: stream word %h with no word written", $time, out_data);
			end else begin
				head = expected_q.pop_front();
				if (out_data !== head) begin
					stream_errors++;
					$display("ERROR %0t: stream word %h, expected %h", $time, out_data, head);
				end
			end
		end
	end

	always @(posedge check_end) begin
		if (words_in != exp_words || words_out != exp_words) begin
			stream_errors++;
			$display("ERROR %0t: %0d words accepted and %0d streamed, expected %0d",
				$time, words_in, words_out, exp_words);
		end
	end

endmodule

`default_nettype wire

/* sim/tb_clocks.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clocks #(
	parameter int RCLK_HALF_NS = 20,
	parameter int WCLK_HALF_NS = 14,
	parameter int RESET_CYCLES = 10
) (
	output logic rclk,
	output logic wclk,
	output logic reset_n
);

	initial begin
		rclk = 1'b0;
		forever #(RCLK_HALF_NS) rclk = ~rclk;
	end

	initial begin
		wclk = 1'b0;
		forever #(WCLK_HALF_NS) wclk = ~wclk;
	end

	// Reset is released on a falling rclk edge, away from any rising edge.
	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge rclk);
		@(negedge rclk);
		reset_n = 1'b1;
	end

endmodule

`default_nettype wire

/* src/fifo_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_bridge_top #(
	parameter int DATA_W     = fifo_bridge_pkg::DEFAULT_DATA_W,
	parameter int DEPTH_LOG2 = fifo_bridge_pkg::DEFAULT_DEPTH_LOG2
) (
	input  logic                                  wclk,
	input  logic                                  rclk,
	input  logic                                  reset_n,
	input  logic                                  psel,
	input  logic                                  penable,
	input  logic                                  pwrite,
	input  logic [fifo_bridge_pkg::APB_ADDR_W-1:0] paddr,
	input  logic [DATA_W-1:0]                     pwdata,
	output logic [DATA_W-1:0]                     prdata,
	output logic                                  pready,
	output logic                                  pslverr,
	output logic                                  out_valid,
	output logic [DATA_W-1:0]                     out_data,
	input  logic                                  out_ready
);

	logic                wr_en;
	logic [DATA_W-1:0]   wdata;
	logic                full;
	logic [DEPTH_LOG2:0] wr_level;
	logic                rd_en;
	logic [DATA_W-1:0]   rdata;
	logic                empty;

	apb_fifo_port #(
		.DATA_W     (DATA_W),
		.DEPTH_LOG2 (DEPTH_LOG2)
	) u_apb_port (
		.reset_n  (reset_n),
		.wclk     (wclk),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.wr_en    (wr_en),
		.wdata    (wdata),
		.full     (full),
		.wr_level (wr_level)
	);

	async_fifo #(
		.payload_t  (logic [DATA_W-1:0]),
		.DEPTH_LOG2 (DEPTH_LOG2)
	) u_fifo (
		.reset_n  (reset_n),
		.wclk     (wclk),
		.wr_en    (wr_en),
		.wdata    (wdata),
		.full     (full),
		.wr_level (wr_level),
		.rclk     (rclk),
		.rd_en    (rd_en),
		.rdata    (rdata),
		.empty    (empty)
	);

	stream_read_stage #(
		.DATA_W (DATA_W)
	) u_read_stage (
		.reset_n   (reset_n),
		.rclk      (rclk),
		.empty     (empty),
		.rd_en     (rd_en),
		.rdata     (rdata),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ready (out_ready)
	);

endmodule

`default_nettype wire

/* src/stream_read_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_read_stage #(
	parameter int DATA_W = fifo_bridge_pkg::DEFAULT_DATA_W
) (
	input  logic              reset_n,
	input  logic              rclk,
	input  logic              empty,
	output logic              rd_en,
	input  logic [DATA_W-1:0] rdata,
	output logic              out_valid,
	output logic [DATA_W-1:0] out_data,
	input  logic              out_ready
);

	// Refill when a word waits and the output slot is free or being taken now.
	assign rd_en = !empty && (!out_valid || out_ready);

	always_ff @(posedge rclk or negedge reset_n) begin
		if (!reset_n) begin
			out_valid <= 1'b0;
		end else if (rd_en) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// The RAM read register is the output register.
	assign out_data = rdata;

	// The RAM only reloads on a pop, so a stalled word must stay put.
	a_hold_while_stalled: assert property (
		@(posedge rclk) disable iff (!reset_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data))
	) else $error("Output stream word changed while stalled");

endmodule

`default_nettype wire

/* src/apb_fifo_port.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_fifo_port #(
	parameter int DATA_W     = fifo_bridge_pkg::DEFAULT_DATA_W,
	parameter int DEPTH_LOG2 = fifo_bridge_pkg::DEFAULT_DEPTH_LOG2
) (
	input  logic                                  reset_n,
	input  logic                                  wclk,
	input  logic                                  psel,
	input  logic                                  penable,
	input  logic                                  pwrite,
	input  logic [fifo_bridge_pkg::APB_ADDR_W-1:0] paddr,
	input  logic [DATA_W-1:0]                     pwdata,
	output logic [DATA_W-1:0]                     prdata,
	output logic                                  pready,
	output logic                                  pslverr,
	output logic                                  wr_en,
	output logic [DATA_W-1:0]                     wdata,
	input  logic                                  full,
	input  logic [DEPTH_LOG2:0]                   wr_level
);

	import fifo_bridge_pkg::*;

	localparam int FULL_BIT = 7;

	logic              access;
	logic              data_wr;
	logic              status_rd;
	logic              bad_access;
	logic [DATA_W-1:0] status_word;

	assign access    = psel && penable;
	assign data_wr   = pwrite && (paddr == ADDR_DATA);
	assign status_rd = !pwrite && (paddr == ADDR_STATUS);

	// Only a DATA write or a STATUS read is a legal transfer.
	assign bad_access = !(data_wr || status_rd);

	always_comb begin
		status_word = '0;
		status_word[DEPTH_LOG2:0] = wr_level;
		status_word[FULL_BIT] = full;
	end

	// A DATA write waits in the access phase until the FIFO has room.
	assign pready  = access && !(data_wr && full);
	assign pslverr = access && bad_access;
	assign prdata  = (access && status_rd) ? status_word : '0;

	// The push coincides with the completing cycle, so each transfer stores one word.
	assign wr_en = access && data_wr && !full;
	assign wdata = pwdata;

	a_stable_while_waiting: assert property (
		@(posedge wclk) disable iff (!reset_n)
		(access && !pready) |=> (psel && penable && $stable(paddr) && $stable(pwdata))
	) else $error("APB address or write data changed during wait states");

endmodule

`default_nettype wire

/* src/async_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module async_fifo #(
	parameter type payload_t = logic [fifo_bridge_pkg::DEFAULT_DATA_W-1:0],
	parameter int  DEPTH_LOG2 = fifo_bridge_pkg::DEFAULT_DEPTH_LOG2
) (
	input  logic                reset_n,
	input  logic                wclk,
	input  logic                wr_en,
	input  payload_t            wdata,
	output logic                full,
	output logic [DEPTH_LOG2:0] wr_level,
	input  logic                rclk,
	input  logic                rd_en,
	output payload_t            rdata,
	output logic                empty
);

	// Pointers carry one extra bit to tell a full FIFO from an empty one.
	logic [DEPTH_LOG2:0] wptr;
	logic [DEPTH_LOG2:0] rptr;
	logic [DEPTH_LOG2:0] wptr_rclk;
	logic [DEPTH_LOG2:0] rptr_wclk;

	always_ff @(posedge wclk or negedge reset_n) begin
		if (!reset_n) begin
			wptr <= '0;
		end else if (wr_en) begin
			wptr <= wptr + 1'b1;
		end
	end

	always_ff @(posedge rclk or negedge reset_n) begin
		if (!reset_n) begin
			rptr <= '0;
		end else if (rd_en) begin
			rptr <= rptr + 1'b1;
		end
	end

	assign full = (wptr[DEPTH_LOG2-1:0] == rptr_wclk[DEPTH_LOG2-1:0]) &&
		(wptr[DEPTH_LOG2] != rptr_wclk[DEPTH_LOG2]);
	assign empty = (rptr == wptr_rclk);

	// The synchronized read pointer lags, so the level can only read high, never low.
	assign wr_level = wptr - rptr_wclk;

	gray_ptr_sync #(
		.DEPTH_LOG2 (DEPTH_LOG2)
	) u_wptr_sync (
		.reset_n (reset_n),
		.src_clk (wclk),
		.dst_clk (rclk),
		.src_ptr (wptr),
		.dst_ptr (wptr_rclk)
	);

	gray_ptr_sync #(
		.DEPTH_LOG2 (DEPTH_LOG2)
	) u_rptr_sync (
		.reset_n (reset_n),
		.src_clk (rclk),
		.dst_clk (wclk),
		.src_ptr (rptr),
		.dst_ptr (rptr_wclk)
	);

	dual_clock_ram #(
		.payload_t  (payload_t),
		.DEPTH_LOG2 (DEPTH_LOG2)
	) u_ram (
		.wclk  (wclk),
		.wr_en (wr_en),
		.waddr (wptr[DEPTH_LOG2-1:0]),
		.wdata (wdata),
		.rclk  (rclk),
		.rd_en (rd_en),
		.raddr (rptr[DEPTH_LOG2-1:0]),
		.rdata (rdata)
	);

	// The producer and consumer are trusted to respect the flags.
	a_no_push_when_full: assert property (
		@(posedge wclk) disable iff (!reset_n) wr_en |-> !full
	) else $error("Push while FIFO full");

	a_no_pop_when_empty: assert property (
		@(posedge rclk) disable iff (!reset_n) rd_en |-> !empty
	) else $error("Pop while FIFO empty");

endmodule

`default_nettype wire

/* src/dual_clock_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_clock_ram #(
	parameter type payload_t = logic [fifo_bridge_pkg::DEFAULT_DATA_W-1:0],
	parameter int  DEPTH_LOG2 = fifo_bridge_pkg::DEFAULT_DEPTH_LOG2
) (
	input  logic                  wclk,
	input  logic                  wr_en,
	input  logic [DEPTH_LOG2-1:0] waddr,
	input  payload_t              wdata,
	input  logic                  rclk,
	input  logic                  rd_en,
	input  logic [DEPTH_LOG2-1:0] raddr,
	output payload_t              rdata
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	payload_t mem [DEPTH];

	always_ff @(posedge wclk) begin
		if (wr_en) begin
			mem[waddr] <= wdata;
		end
	end

	// The read register holds its word until the next pop.
	always_ff @(posedge rclk) begin
		if (rd_en) begin
			rdata <= mem[raddr];
		end
	end

endmodule

`default_nettype wire

/* src/gray_ptr_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_sync #(
	parameter int DEPTH_LOG2 = fifo_bridge_pkg::DEFAULT_DEPTH_LOG2
) (
	input  logic                  reset_n,
	input  logic                  src_clk,
	input  logic                  dst_clk,
	input  logic [DEPTH_LOG2:0]   src_ptr,
	output logic [DEPTH_LOG2:0]   dst_ptr
);

	import fifo_bridge_pkg::*;

	logic [DEPTH_LOG2:0] gray_q;
	logic [DEPTH_LOG2:0] sync_q [SYNC_STAGES];

	// The Gray value leaves the source domain from a flop, so only one bit can be in flight.
	always_ff @(posedge src_clk or negedge reset_n) begin
		if (!reset_n) begin
			gray_q <= '0;
		end else begin
			gray_q <= (src_ptr >> 1) ^ src_ptr;
		end
	end

	always_ff @(posedge dst_clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < SYNC_STAGES; i++) begin
				sync_q[i] <= '0;
			end
		end else begin
			sync_q[0] <= gray_q;
			for (int i = 1; i < SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	// Each binary bit is the XOR of all Gray bits at or above it.
	always_comb begin
		dst_ptr[DEPTH_LOG2] = sync_q[SYNC_STAGES-1][DEPTH_LOG2];
		for (int i = DEPTH_LOG2 - 1; i >= 0; i--) begin
			dst_ptr[i] = dst_ptr[i+1] ^ sync_q[SYNC_STAGES-1][i];
		end
	end

	// The pointer feeding this block must never step by more than one per cycle.
	a_gray_one_bit: assert property (
		@(posedge src_clk) disable iff (!reset_n)
		$countones(gray_q ^ $past(gray_q)) <= 1
	) else $error("Gray pointer changed by more than one bit");

endmodule

`default_nettype wire

/* src/fifo_bridge_pkg.sv */
`default_nettype none

package fifo_bridge_pkg;

	// Width of the APB address bus.
	localparam int APB_ADDR_W = 4;

	// Register map.
	// A write to DATA pushes one word into the FIFO.
	localparam logic [APB_ADDR_W-1:0] ADDR_DATA = 4'h0;

	// STATUS returns the write-side fill level in the low bits and full in bit 7.
	localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 4'h4;

	// Default payload width and FIFO depth exponent (16 entries).
	localparam int DEFAULT_DATA_W = 8;
	localparam int DEFAULT_DEPTH_LOG2 = 4;

	// Number of flops in each pointer synchronizer.
	localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire
